//--- Makefile
TOP = matmul_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- build.f
src/matmul_pkg.sv
src/matmul_ctrl_if.sv
src/row_ram.sv
src/matmul_sequencer.sv
src/operand_feeder.sv
src/processing_element.sv
src/systolic_array.sv
src/result_writer.sv
src/matmul_top.sv
tests/matmul_tb.sv

//--- src/matmul_ctrl_if.sv
`timescale 1ns/100ps

interface matmul_ctrl_if;
  import matmul_pkg::*;

  // operand addresses are being issued
  logic feed_en;
  // follows i_start low, empties the datapath
  logic clear;
  // one-cycle pulse to latch the accumulators
  logic capture;
  logic wb_en;
  addr_t wb_row;

  modport seq (
    output feed_en, clear, capture, wb_en, wb_row
  );

  modport feed (
    input feed_en, clear
  );

  modport array (
    input clear
  );

  modport wb (
    input capture, wb_en, wb_row
  );

endinterface

//--- src/matmul_pkg.sv
package matmul_pkg;

  // element and memory geometry
  localparam int DATA_W = 8;
  localparam int ADDR_W = 7;
  localparam int MEM_DEPTH = 128;
  localparam int ARRAY_N = 4;

  // product register plus accumulator register
  localparam int MAC_STAGES = 2;

  typedef logic signed [DATA_W-1:0] elem_t;

  // element j sits in slice j, counting from the lsb
  typedef elem_t [ARRAY_N-1:0] row_word_t;

  typedef logic [ADDR_W-1:0] addr_t;

  localparam elem_t ELEM_MAX = {1'b0, {(DATA_W-1){1'b1}}};
  localparam elem_t ELEM_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  // signed product, clamped to the element range
  function automatic elem_t sat_mult(input elem_t a, input elem_t b);
    logic signed [2*DATA_W-1:0] full;
    full = a * b;
    if (full > ELEM_MAX) begin
      return ELEM_MAX;
    end
    if (full < ELEM_MIN) begin
      return ELEM_MIN;
    end
    return elem_t'(full);
  endfunction

endpackage

//--- src/matmul_sequencer.sv
`timescale 1ns/100ps

module matmul_sequencer #(
  parameter int ARRAY_N = matmul_pkg::ARRAY_N
) (
  input  logic clk,
  input  logic reset,
  input  logic i_start,
  output logic o_done,
  matmul_ctrl_if.seq ctrl
);
  import matmul_pkg::*;

  // last operand pair reaches cell (N-1,N-1) at this count
  localparam int LAST_HIT = 3*ARRAY_N - 2;
  localparam int CAPTURE_CNT = LAST_HIT + MAC_STAGES + 1;
  localparam int WB_FIRST = CAPTURE_CNT + 1;
  localparam int WB_LAST = CAPTURE_CNT + ARRAY_N;
  // writer registers its port, so the last word lands one cycle later
  localparam int DONE_CNT = WB_LAST + 1;
  localparam int CNT_W = $clog2(DONE_CNT + 2);

  logic running;
  logic [CNT_W-1:0] cnt;

  // count starts at zero on the first edge with i_start high
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      running <= 1'b0;
      cnt <= '0;
      o_done <= 1'b0;
    end else begin
      running <= 1'b1;
      if (running && !o_done) begin
        cnt <= cnt + 1'b1;
        if (cnt == CNT_W'(DONE_CNT)) begin
          o_done <= 1'b1;
        end
      end
    end
  end

  assign ctrl.clear = !i_start;
  assign ctrl.feed_en = running && (cnt < CNT_W'(ARRAY_N));
  assign ctrl.capture = running && (cnt == CNT_W'(CAPTURE_CNT));
  assign ctrl.wb_en = running && (cnt >= CNT_W'(WB_FIRST)) && (cnt <= CNT_W'(WB_LAST));
  assign ctrl.wb_row = addr_t'(cnt - CNT_W'(WB_FIRST));

  a_capture_not_wb: assert property (
    @(posedge clk) disable iff (reset) !(ctrl.capture && ctrl.wb_en)
  );

  // done drops on the edge after i_start falls
  a_done_follows_start: assert property (
    @(posedge clk) disable iff (reset) !i_start |=> !o_done
  );

endmodule

//--- src/matmul_top.sv
`timescale 1ns/100ps

module matmul_top #(
  parameter int ARRAY_N = matmul_pkg::ARRAY_N,
  parameter int MEM_DEPTH = matmul_pkg::MEM_DEPTH
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  i_we_a,
  input  logic                  i_we_b,
  input  logic                  i_start,
  input  matmul_pkg::row_word_t i_data,
  input  matmul_pkg::addr_t     i_addr,
  output logic                  o_done,
  output matmul_pkg::row_word_t o_rdata
);
  import matmul_pkg::*;

  matmul_ctrl_if ctrl ();

  addr_t a_rd_addr;
  addr_t b_rd_addr;
  addr_t c_waddr;
  row_word_t a_word;
  row_word_t b_word;
  row_word_t a_skew;
  row_word_t b_skew;
  row_word_t c_wdata;
  row_word_t acc [ARRAY_N];
  logic c_we;

  // host writes A and B; the feeder reads them
  row_ram #(.DEPTH(MEM_DEPTH)) mem_a (
    .clk(clk), .i_we(i_we_a), .i_waddr(i_addr), .i_raddr(a_rd_addr),
    .i_wdata(i_data), .o_rdata(a_word)
  );

  row_ram #(.DEPTH(MEM_DEPTH)) mem_b (
    .clk(clk), .i_we(i_we_b), .i_waddr(i_addr), .i_raddr(b_rd_addr),
    .i_wdata(i_data), .o_rdata(b_word)
  );

  // writer fills C; the host reads it back
  row_ram #(.DEPTH(MEM_DEPTH)) mem_c (
    .clk(clk), .i_we(c_we), .i_waddr(c_waddr), .i_raddr(i_addr),
    .i_wdata(c_wdata), .o_rdata(o_rdata)
  );

  matmul_sequencer #(.ARRAY_N(ARRAY_N)) u_sequencer (
    .clk(clk), .reset(reset), .i_start(i_start), .o_done(o_done), .ctrl(ctrl.seq)
  );

  operand_feeder #(.ARRAY_N(ARRAY_N)) u_feeder (
    .clk(clk), .reset(reset), .ctrl(ctrl.feed),
    .o_a_addr(a_rd_addr), .o_b_addr(b_rd_addr),
    .i_a_word(a_word), .i_b_word(b_word),
    .o_a_skew(a_skew), .o_b_skew(b_skew)
  );

  systolic_array #(.ARRAY_N(ARRAY_N)) u_array (
    .clk(clk), .reset(reset), .ctrl(ctrl.array),
    .i_a_skew(a_skew), .i_b_skew(b_skew), .o_acc(acc)
  );

  result_writer #(.ARRAY_N(ARRAY_N)) u_writer (
    .clk(clk), .reset(reset), .ctrl(ctrl.wb), .i_acc(acc),
    .o_we(c_we), .o_waddr(c_waddr), .o_wdata(c_wdata)
  );

endmodule

//--- src/operand_feeder.sv
`timescale 1ns/100ps

module operand_feeder #(
  parameter int ARRAY_N = matmul_pkg::ARRAY_N
) (
  input  logic                  clk,
  input  logic                  reset,
  matmul_ctrl_if.feed           ctrl,
  output matmul_pkg::addr_t     o_a_addr,
  output matmul_pkg::addr_t     o_b_addr,
  input  matmul_pkg::row_word_t i_a_word,
  input  matmul_pkg::row_word_t i_b_word,
  output matmul_pkg::row_word_t o_a_skew,
  output matmul_pkg::row_word_t o_b_skew
);
  import matmul_pkg::*;

  addr_t rd_addr;
  logic feed_d;
  row_word_t a_win;
  row_word_t b_win;

  // A columns and B rows share the same index k
  always_ff @(posedge clk) begin
    if (reset || ctrl.clear) begin
      rd_addr <= '0;
      feed_d <= 1'b0;
    end else begin
      feed_d <= ctrl.feed_en;
      if (ctrl.feed_en) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  assign o_a_addr = rd_addr;
  assign o_b_addr = rd_addr;

  // read data is one cycle behind the address window
  assign a_win = feed_d ? i_a_word : '0;
  assign b_win = feed_d ? i_b_word : '0;

  for (genvar i = 0; i < ARRAY_N; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign o_a_skew[0] = a_win[0];
      assign o_b_skew[0] = b_win[0];
    end else begin : g_delay
      // lane i waits i cycles
      elem_t a_dly [i];
      elem_t b_dly [i];

      always_ff @(posedge clk) begin
        if (reset || ctrl.clear) begin
          for (int s = 0; s < i; s++) begin
            a_dly[s] <= '0;
            b_dly[s] <= '0;
          end
        end else begin
          a_dly[0] <= a_win[i];
          b_dly[0] <= b_win[i];
          for (int s = 1; s < i; s++) begin
            a_dly[s] <= a_dly[s-1];
            b_dly[s] <= b_dly[s-1];
          end
        end
      end

      assign o_a_skew[i] = a_dly[i-1];
      assign o_b_skew[i] = b_dly[i-1];
    end
  end

endmodule

//--- src/processing_element.sv
`timescale 1ns/100ps

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  matmul_pkg::elem_t i_a,
  input  matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t o_a,
  output matmul_pkg::elem_t o_b,
  output matmul_pkg::elem_t o_acc
);
  import matmul_pkg::*;

  elem_t prod_q;
  elem_t acc_q;

  // a moves right, b moves down
  always_ff @(posedge clk) begin
    if (reset) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  // stage one saturates the product, stage two accumulates
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      prod_q <= '0;
      acc_q <= '0;
    end else begin
      prod_q <= sat_mult(i_a, i_b);
      // plain 8-bit add, wraps on overflow
      acc_q <= acc_q + prod_q;
    end
  end

  assign o_acc = acc_q;

endmodule

//--- src/result_writer.sv
`timescale 1ns/100ps

module result_writer #(
  parameter int ARRAY_N = matmul_pkg::ARRAY_N
) (
  input  logic                  clk,
  input  logic                  reset,
  matmul_ctrl_if.wb             ctrl,
  input  matmul_pkg::row_word_t i_acc [ARRAY_N],
  output logic                  o_we,
  output matmul_pkg::addr_t     o_waddr,
  output matmul_pkg::row_word_t o_wdata
);
  import matmul_pkg::*;

  localparam int ROW_W = (ARRAY_N > 1) ? $clog2(ARRAY_N) : 1;

  row_word_t cap_q [ARRAY_N];

  // snapshot of the whole grid, taken once per run
  always_ff @(posedge clk) begin
    if (ctrl.capture) begin
      cap_q <= i_acc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_we <= 1'b0;
    end else begin
      o_we <= ctrl.wb_en;
    end
  end

  // row r of C goes to address r
  always_ff @(posedge clk) begin
    o_waddr <= ctrl.wb_row;
    o_wdata <= cap_q[ctrl.wb_row[ROW_W-1:0]];
  end

  // sequencer must keep the row index inside the grid
  a_wb_row_range: assert property (
    @(posedge clk) disable iff (reset) ctrl.wb_en |-> (ctrl.wb_row < ARRAY_N)
  );

endmodule

//--- src/row_ram.sv
`timescale 1ns/100ps

module row_ram #(
  parameter int DEPTH = matmul_pkg::MEM_DEPTH
) (
  input  logic                  clk,
  input  logic                  i_we,
  input  matmul_pkg::addr_t     i_waddr,
  input  matmul_pkg::addr_t     i_raddr,
  input  matmul_pkg::row_word_t i_wdata,
  output matmul_pkg::row_word_t o_rdata
);
  import matmul_pkg::*;

  row_word_t mem [DEPTH];

  // write port and registered read port are independent
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
    o_rdata <= mem[i_raddr];
  end

  // host or writer must stay inside the memory
  a_waddr_range: assert property (
    @(posedge clk) i_we |-> (i_waddr < DEPTH)
  );

endmodule

//--- src/systolic_array.sv
`timescale 1ns/100ps

module systolic_array #(
  parameter int ARRAY_N = matmul_pkg::ARRAY_N
) (
  input  logic                  clk,
  input  logic                  reset,
  matmul_ctrl_if.array          ctrl,
  input  matmul_pkg::row_word_t i_a_skew,
  input  matmul_pkg::row_word_t i_b_skew,
  output matmul_pkg::row_word_t o_acc [ARRAY_N]
);
  import matmul_pkg::*;

  // link [i][j] feeds cell (i,j); the last index is the far edge
  elem_t a_link [ARRAY_N][ARRAY_N+1];
  elem_t b_link [ARRAY_N+1][ARRAY_N];

  for (genvar n = 0; n < ARRAY_N; n++) begin : g_edge
    assign a_link[n][0] = i_a_skew[n];
    assign b_link[0][n] = i_b_skew[n];
  end

  for (genvar i = 0; i < ARRAY_N; i++) begin : g_row
    for (genvar j = 0; j < ARRAY_N; j++) begin : g_col
      processing_element u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (ctrl.clear),
        .i_a     (a_link[i][j]),
        .i_b     (b_link[i][j]),
        .o_a     (a_link[i][j+1]),
        .o_b     (b_link[i+1][j]),
        .o_acc   (o_acc[i][j])
      );
    end
  end

endmodule

//--- tests/matmul_stimulus.txt
# each case is four lines: name, then A column words 0..3, B row words 0..3, expected C rows 0..3
# words are hex, element j in byte j counting from the lsb
identity
00000001 00000100 00010000 01000000
04030201 0605feff 207f8010 01aa5500
04030201 0605feff 207f8010 01aa5500
small_signed
fd020001 01ff0302 020001ff 0101fe00
01ff0002 fe000101 01020300 000102ff
fcfdff04 fb000205 04ff0102 fd0809fa
saturation
00000010 0000f000 00640000 80000000
0007f808 ff02f708 ff01fe02 008001ff
0070807f 10e07f80 9c64807f 007f807f
acc_wrap
7f9c0164 7f9c0164 7f000164 7f000100
00010101 00000101 01010101 01010001
64c82c2c 02030304 009c3838 fe7d7dfc
sat_then_wrap
7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f
02020202 fe020202 fefe0202 fefefe02
fffefdfc fffefdfc fffefdfc fffefdfc
zero_after_full
00000000 00000000 00000000 00000000
01ff0002 fe000101 01020300 000102ff
00000000 00000000 00000000 00000000

//--- tests/matmul_tb.sv
`timescale 1ns/100ps

module matmul_tb;
  import matmul_pkg::*;

  localparam string STIM_FILE = "tests/matmul_stimulus.txt";
  localparam int MAX_CASES = 32;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_CASE = 100;
  localparam int DONE_LIMIT = 80;

  logic clk;
  logic reset;
  logic i_we_a;
  logic i_we_b;
  logic i_start;
  row_word_t i_data;
  addr_t i_addr;
  logic o_done;
  row_word_t o_rdata;

  // sections per case: 0 is A, 1 is B, 2 is expected C
  string case_name [MAX_CASES];
  row_word_t case_words [MAX_CASES][3][ARRAY_N];
  int num_cases = 0;
  bit cases_ready = 0;
  int errors = 0;
  int checks = 0;

  matmul_top dut0 (
    .clk(clk), .reset(reset), .i_we_a(i_we_a), .i_we_b(i_we_b), .i_start(i_start),
    .i_data(i_data), .i_addr(i_addr), .o_done(o_done), .o_rdata(o_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // skips comment and blank lines
  task automatic read_data_line(input int fd, output string line, output bit found);
    int rc;
    byte c;
    bit eof;
    found = 0;
    eof = 0;
    line = "";
    while (!found && !eof) begin
      rc = $fgets(line, fd);
      if (rc == 0) begin
        eof = 1;
      end else begin
        c = line.getc(0);
        if (c != "#" && c != "\n" && c != "\r" && c != " ") begin
          found = 1;
        end
      end
    end
  endtask

  task automatic load_cases();
    int fd;
    int cnt;
    string line;
    string nm;
    bit found;
    logic [31:0] w0, w1, w2, w3;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open stimulus file %s", STIM_FILE);
    end else begin
      found = 1;
      while (found && num_cases < MAX_CASES) begin
        read_data_line(fd, line, found);
        if (found) begin
          cnt = $sscanf(line, "%s", nm);
          case_name[num_cases] = nm;
          for (int s = 0; s < 3; s++) begin
            read_data_line(fd, line, found);
            cnt = 0;
            if (found) begin
              cnt = $sscanf(line, "%h %h %h %h", w0, w1, w2, w3);
            end
            checks++;
            assert (cnt == 4) else begin
              errors++;
              $display("stimulus case %s has a missing or short word line", nm);
            end
            case_words[num_cases][s][0] = w0;
            case_words[num_cases][s][1] = w1;
            case_words[num_cases][s][2] = w2;
            case_words[num_cases][s][3] = w3;
          end
          num_cases++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_done_low(input string nm, input string where);
    checks++;
    assert (o_done === 1'b0) else begin
      errors++;
      $display("o_done is high %s in case %s", where, nm);
    end
  endtask

  task automatic run_case(input int c);
    string nm;
    int cycles;
    row_word_t exp_row;
    nm = case_name[c];
    // A columns, then B rows, written while i_start is low
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < ARRAY_N; k++) begin
        @(posedge clk);
        #1;
        check_done_low(nm, "while loading");
        i_we_a = (s == 0);
        i_we_b = (s == 1);
        i_addr = addr_t'(k);
        i_data = case_words[c][s][k];
      end
    end
    @(posedge clk);
    #1;
    i_we_a = 1'b0;
    i_we_b = 1'b0;
    i_start = 1'b1;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles == 1) begin
        check_done_low(nm, "on the first cycle of the run");
      end
    end while (!o_done && cycles < DONE_LIMIT);
    checks++;
    assert (o_done === 1'b1) else begin
      errors++;
      $display("o_done did not rise within %0d cycles in case %s", DONE_LIMIT, nm);
    end
    i_start = 1'b0;
    @(posedge clk);
    #1;
    check_done_low(nm, "one cycle after i_start fell");
    // one cycle of read latency per row
    for (int r = 0; r < ARRAY_N; r++) begin
      i_addr = addr_t'(r);
      @(posedge clk);
      #1;
      exp_row = case_words[c][2][r];
      checks++;
      assert (o_rdata === exp_row) else begin
        errors++;
        $display("** Error: %s C row %0d expected %h actual %h", nm, r, exp_row, o_rdata);
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    i_we_a = 1'b0;
    i_we_b = 1'b0;
    i_start = 1'b0;
    i_data = '0;
    i_addr = '0;
    load_cases();
    cases_ready = 1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    check_done_low("reset", "right after reset");
    checks++;
    assert (num_cases > 0) else begin
      errors++;
      $display("no test cases were read from %s", STIM_FILE);
    end
    for (int c = 0; c < num_cases; c++) begin
      run_case(c);
    end
    $display("cases: %0d, checks: %0d, errors: %0d", num_cases, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // limit scales with the number of cases read
  initial begin
    wait (cases_ready);
    repeat (RESET_CYCLES + (num_cases + 1) * CYCLES_PER_CASE) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles",
             RESET_CYCLES + (num_cases + 1) * CYCLES_PER_CASE);
    $display("test failed");
    $finish;
  end

endmodule
